/* logic/fpu_pkg.sv */
package fpu_pkg;

    // ====================
    // Number format
    // ====================

    // IEEE 754 single precision layout, sign in the MSB
    typedef struct packed {
        logic       sign;
        logic [7:0] exponent;
        logic [22:0] significand;
    } float_t;

    // Bits below the kept significand, used by the rounding stage
    typedef struct packed {
        logic guard;
        logic round;
        logic sticky;
    } round_bits_t;

    // Operation identifier, lets out of order results be matched at the output
    typedef logic [3:0] tag_t;

    typedef enum logic [1:0] {
        OP_MUL = 2'd0,
        OP_MIN = 2'd1,
        OP_MAX = 2'd2
    } fpu_op_t;

    typedef struct packed {
        logic invalid;
        logic overflow;
        logic underflow;
    } fpu_flags_t;

    // Operand decode shared by both execution units
    typedef struct packed {
        logic is_nan;
        logic is_infinity;
        logic is_zero;
        logic is_subnormal;
    } float_class_t;

    localparam int BIAS = 127;
    // Smallest biased exponent of a normal number
    localparam int MIN_EXP = 1;
    // Quiet NaN with only the significand MSB set
    localparam float_t CANONICAL_NAN = '{sign: 1'b0, exponent: 8'hFF, significand: 23'h400000};

endpackage : fpu_pkg

/* logic/result_bus_if.sv */
`timescale 1ns/10ps

// One execution unit result on its way to the shared rounding stage
interface result_bus_if import fpu_pkg::*; ();

    float_t      result;
    round_bits_t round_bits;
    fpu_flags_t  flags;
    tag_t        tag;
    // Level, stays high until the cycle in which grant is high
    logic        valid;
    logic        grant;

    modport producer (
        output result, round_bits, flags, tag, valid,
        input  grant
    );

    modport consumer (
        input  result, round_bits, flags, tag, valid,
        output grant
    );

endinterface : result_bus_if

/* logic/float_classifier.sv */
`timescale 1ns/10ps

module float_classifier import fpu_pkg::*; (
    input  float_t       operand_i,
    output float_class_t class_o
);

    logic exp_all_ones;
    logic exp_all_zeros;
    logic sig_zero;

    assign exp_all_ones  = (operand_i.exponent == 8'hFF);
    assign exp_all_zeros = (operand_i.exponent == 8'h00);
    assign sig_zero      = (operand_i.significand == '0);

    // Saturated exponent holds NaN or infinity, told apart by the significand
    assign class_o.is_nan      = exp_all_ones & !sig_zero;
    assign class_o.is_infinity = exp_all_ones & sig_zero;

    // Zero exponent holds zero or a subnormal, same test on the significand
    assign class_o.is_zero      = exp_all_zeros & sig_zero;
    assign class_o.is_subnormal = exp_all_zeros & !sig_zero;

endmodule : float_classifier

/* logic/significand_multiplier.sv */
`timescale 1ns/10ps

module significand_multiplier #(
    parameter int CORE_STAGES = 2
) (
    input  logic        clk_i,
    input  logic        enable_i,
    input  logic [23:0] a_i,
    input  logic [23:0] b_i,
    output logic [47:0] product_o
);

    generate
        if (CORE_STAGES == 0) begin : g_comb
            // No pipeline, the product is seen in the same cycle
            assign product_o = a_i * b_i;
        end else begin : g_pipe
            logic [CORE_STAGES-1:0][47:0] product_q;

            // The whole chain advances together so the side pipe stays aligned
            always_ff @(posedge clk_i) begin
                if (enable_i) begin
                    product_q[0] <= a_i * b_i;
                    for (int i = 1; i < CORE_STAGES; i++) begin
                        product_q[i] <= product_q[i-1];
                    end
                end
            end

            assign product_o = product_q[CORE_STAGES-1];
        end
    endgenerate

endmodule : significand_multiplier

/* logic/float_multiplier.sv */
`timescale 1ns/10ps

module float_multiplier import fpu_pkg::*; #(
    parameter int CORE_STAGES = 2
) (
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  logic         stall_i,
    input  logic         flush_i,
    input  float_t       multiplicand_i,
    input  float_t       multiplier_i,
    input  float_class_t class_a_i,
    input  float_class_t class_b_i,
    input  tag_t         tag_i,
    input  logic         valid_i,
    result_bus_if.producer res_o
);

    // Everything that rides next to the significand product
    typedef struct packed {
        logic              sign;
        logic              invalid;
        logic              zero;
        logic              infinity;
        logic signed [9:0] exponent;
        tag_t              tag;
    } side_t;

    // ====================
    // Stage 0
    // ====================

    side_t       side_d;
    side_t       side_stg0;
    logic [23:0] sig_a_stg0;
    logic [23:0] sig_b_stg0;
    logic        valid_stg0;

    assign side_d.sign = multiplicand_i.sign ^ multiplier_i.sign;
    // NaN on either side, or infinity times a true zero
    assign side_d.invalid = class_a_i.is_nan | class_b_i.is_nan
                          | (class_a_i.is_infinity & class_b_i.is_zero)
                          | (class_b_i.is_infinity & class_a_i.is_zero);
    // Subnormal operands are taken as zero since subnormals are not carried
    assign side_d.zero = class_a_i.is_zero | class_a_i.is_subnormal
                       | class_b_i.is_zero | class_b_i.is_subnormal;
    assign side_d.infinity = class_a_i.is_infinity | class_b_i.is_infinity;
    // Ten bits keep both the negative range and the overflow range
    assign side_d.exponent = {2'b00, multiplicand_i.exponent}
                           + {2'b00, multiplier_i.exponent} - 10'(BIAS);
    assign side_d.tag = tag_i;

    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            side_stg0  <= side_d;
            // Hidden bit restored for normal operands only
            sig_a_stg0 <= {!(class_a_i.is_zero | class_a_i.is_subnormal),
                           multiplicand_i.significand};
            sig_b_stg0 <= {!(class_b_i.is_zero | class_b_i.is_subnormal),
                           multiplier_i.significand};
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_stg0 <= 1'b0;
        end else if (flush_i) begin
            valid_stg0 <= 1'b0;
        end else if (!stall_i) begin
            valid_stg0 <= valid_i;
        end
    end

    // ====================
    // Core and side pipe
    // ====================

    logic [47:0]              product;
    logic [47:0]              product_stg1;
    side_t [CORE_STAGES:0]    side_pipe;
    logic  [CORE_STAGES:0]    valid_pipe;

    significand_multiplier #(
        .CORE_STAGES(CORE_STAGES)
    ) u_core (
        .clk_i    (clk_i),
        .enable_i (!stall_i),
        .a_i      (sig_a_stg0),
        .b_i      (sig_b_stg0),
        .product_o(product)
    );

    // One extra slot covers the product register after the core
    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            product_stg1 <= product;
            side_pipe[0] <= side_stg0;
            for (int i = 1; i <= CORE_STAGES; i++) begin
                side_pipe[i] <= side_pipe[i-1];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_pipe <= '0;
        end else if (flush_i) begin
            valid_pipe <= '0;
        end else if (!stall_i) begin
            valid_pipe[0] <= valid_stg0;
            for (int i = 1; i <= CORE_STAGES; i++) begin
                valid_pipe[i] <= valid_pipe[i-1];
            end
        end
    end

    // ====================
    // Normalization
    // ====================

    side_t             side_out;
    logic signed [9:0] exp_norm;
    float_t            result_d;
    round_bits_t       round_d;
    fpu_flags_t        flags_d;
    logic              underflow;
    logic              overflow;

    assign side_out = side_pipe[CORE_STAGES];
    // Product of two values in [1,2) lies in [1,4), so at most one right shift
    assign exp_norm = side_out.exponent + 10'(product_stg1[47]);
    assign underflow = !side_out.zero && (exp_norm < MIN_EXP);
    assign overflow  = side_out.infinity || (exp_norm >= 255);

    always_comb begin
        result_d.sign     = side_out.sign;
        result_d.exponent = exp_norm[7:0];
        if (product_stg1[47]) begin
            result_d.significand = product_stg1[46:24];
            round_d = {product_stg1[23], product_stg1[22], |product_stg1[21:0]};
        end else begin
            result_d.significand = product_stg1[45:23];
            round_d = {product_stg1[22], product_stg1[21], |product_stg1[20:0]};
        end
        flags_d = '0;

        // Special results carry no round bits so the rounder leaves them alone
        if (side_out.invalid) begin
            result_d = CANONICAL_NAN;
            round_d  = '0;
            flags_d.invalid = 1'b1;
        end else if (underflow) begin
            result_d.exponent    = '0;
            result_d.significand = '0;
            round_d = '0;
            flags_d.underflow = 1'b1;
        end else if (overflow) begin
            result_d.exponent    = '1;
            result_d.significand = '0;
            round_d = '0;
            flags_d.overflow = 1'b1;
        end else if (side_out.zero) begin
            result_d.exponent    = '0;
            result_d.significand = '0;
            round_d = '0;
        end
    end

    assign res_o.result     = result_d;
    assign res_o.round_bits = round_d;
    assign res_o.flags      = flags_d;
    assign res_o.tag        = side_out.tag;
    assign res_o.valid      = valid_pipe[CORE_STAGES];

    // A finite product of two normal operands has its leading one in bit 47 or 46
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        res_o.valid && !side_out.zero && !side_out.invalid && !side_out.infinity
        |-> (product_stg1[47:46] != 2'b00));

    // Nothing here can hold a result, so the arbiter has to take it at once
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        res_o.valid |-> res_o.grant);

endmodule : float_multiplier

/* logic/float_min_max.sv */
`timescale 1ns/10ps

module float_min_max import fpu_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  logic         stall_i,
    input  logic         flush_i,
    input  fpu_op_t      op_i,
    input  float_t       operand_a_i,
    input  float_t       operand_b_i,
    input  float_class_t class_a_i,
    input  float_class_t class_b_i,
    input  tag_t         tag_i,
    input  logic         valid_i,
    output logic         busy_o,
    result_bus_if.producer res_o
);

    logic   a_less;
    logic   take_a;
    logic   load;
    logic   valid_q;
    float_t result_q;
    logic   invalid_q;
    tag_t   tag_q;

    // Sign-magnitude order, which also puts -0 below +0
    assign a_less = (operand_a_i.sign != operand_b_i.sign) ? operand_a_i.sign :
                    operand_a_i.sign ? (operand_a_i[30:0] > operand_b_i[30:0]) :
                                       (operand_a_i[30:0] < operand_b_i[30:0]);
    assign take_a = (op_i == OP_MIN) ? a_less : !a_less;

    // The register is free when empty or when its item leaves this cycle
    assign load   = !valid_q || res_o.grant;
    assign busy_o = valid_q && !res_o.grant;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
        end else if (!stall_i && load) begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i && load && valid_i) begin
            tag_q     <= tag_i;
            invalid_q <= class_a_i.is_nan | class_b_i.is_nan;
            if (class_a_i.is_nan || class_b_i.is_nan) begin
                result_q <= CANONICAL_NAN;
            end else begin
                result_q <= take_a ? operand_a_i : operand_b_i;
            end
        end
    end

    assign res_o.result     = result_q;
    // A selected operand is already exact
    assign res_o.round_bits = '0;
    assign res_o.flags      = '{invalid: invalid_q, overflow: 1'b0, underflow: 1'b0};
    assign res_o.tag        = tag_q;
    assign res_o.valid      = valid_q;

    // Issue logic at the top must hold back while a result waits for the bus
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_i |-> !busy_o);

endmodule : float_min_max

/* logic/result_arbiter.sv */
`timescale 1ns/10ps

module result_arbiter import fpu_pkg::*; (
    input  logic clk_i,
    input  logic rst_n_i,
    result_bus_if.consumer mul_i,
    result_bus_if.consumer minmax_i,
    result_bus_if.producer sel_o
);

    logic pick_mul;

    // The multiplier cannot wait and always wins the bus
    assign pick_mul = mul_i.valid;

    assign mul_i.grant    = mul_i.valid && sel_o.grant;
    assign minmax_i.grant = minmax_i.valid && !mul_i.valid && sel_o.grant;

    assign sel_o.valid      = mul_i.valid || minmax_i.valid;
    assign sel_o.result     = pick_mul ? mul_i.result     : minmax_i.result;
    assign sel_o.round_bits = pick_mul ? mul_i.round_bits : minmax_i.round_bits;
    assign sel_o.flags      = pick_mul ? mul_i.flags      : minmax_i.flags;
    assign sel_o.tag        = pick_mul ? mul_i.tag        : minmax_i.tag;

    // A waiting min/max item has to leave as soon as the multiplier bus is quiet
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        minmax_i.valid && !mul_i.valid |-> minmax_i.grant);

endmodule : result_arbiter

/* logic/float_rounder.sv */
`timescale 1ns/10ps

module float_rounder import fpu_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       stall_i,
    input  logic       flush_i,
    result_bus_if.consumer in_i,
    output float_t     result_o,
    output fpu_flags_t flags_o,
    output tag_t       tag_o,
    output logic       valid_o
);

    round_bits_t rb;
    logic        round_up;
    logic [23:0] sig_sum;
    float_t      rounded;
    fpu_flags_t  flags_d;
    logic        valid_q;

    // One register stage, always ready for the selected bus
    assign in_i.grant = 1'b1;

    assign rb = in_i.round_bits;
    // Nearest-even, a tie goes up only when the LSB is odd
    assign round_up = rb.guard & (rb.round | rb.sticky | in_i.result.significand[0]);
    assign sig_sum  = {1'b0, in_i.result.significand} + 24'(round_up);

    always_comb begin
        rounded = in_i.result;
        flags_d = in_i.flags;
        rounded.significand = sig_sum[22:0];
        // Carry out leaves a zero fraction and bumps the exponent
        if (sig_sum[23]) begin
            rounded.exponent = in_i.result.exponent + 8'd1;
            if (rounded.exponent == 8'hFF) begin
                rounded.significand = '0;
                flags_d.overflow = 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            result_o <= rounded;
            flags_o  <= flags_d;
            tag_o    <= in_i.tag;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
        end else if (!stall_i) begin
            valid_q <= in_i.valid;
        end
    end

    // A frozen result is shown once the stall is released
    assign valid_o = valid_q && !stall_i;

endmodule : float_rounder

/* logic/fpu_unit.sv */
`timescale 1ns/10ps

module fpu_unit import fpu_pkg::*; #(
    parameter int CORE_STAGES = 2
) (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       stall_i,
    input  logic       flush_i,
    input  logic       issue_valid_i,
    input  fpu_op_t    issue_op_i,
    input  float_t     operand_a_i,
    input  float_t     operand_b_i,
    input  tag_t       issue_tag_i,
    output logic       busy_o,
    output logic       out_valid_o,
    output float_t     out_result_o,
    output fpu_flags_t out_flags_o,
    output tag_t       out_tag_o
);

    // ====================
    // Issue decode
    // ====================

    float_class_t class_a;
    float_class_t class_b;
    logic         accept;
    logic         mul_valid;
    logic         minmax_valid;

    // Accepted only when nothing is frozen and the min/max output is free
    assign accept       = issue_valid_i && !stall_i && !busy_o;
    assign mul_valid    = accept && (issue_op_i == OP_MUL);
    assign minmax_valid = accept && (issue_op_i != OP_MUL);

    // Both units read the same decode
    float_classifier u_class_a (.operand_i(operand_a_i), .class_o(class_a));
    float_classifier u_class_b (.operand_i(operand_b_i), .class_o(class_b));

    // ====================
    // Units and result path
    // ====================

    result_bus_if mul_bus ();
    result_bus_if minmax_bus ();
    result_bus_if sel_bus ();

    float_multiplier #(
        .CORE_STAGES(CORE_STAGES)
    ) u_mul (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .stall_i       (stall_i),
        .flush_i       (flush_i),
        .multiplicand_i(operand_a_i),
        .multiplier_i  (operand_b_i),
        .class_a_i     (class_a),
        .class_b_i     (class_b),
        .tag_i         (issue_tag_i),
        .valid_i       (mul_valid),
        .res_o         (mul_bus.producer)
    );

    float_min_max u_minmax (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .stall_i    (stall_i),
        .flush_i    (flush_i),
        .op_i       (issue_op_i),
        .operand_a_i(operand_a_i),
        .operand_b_i(operand_b_i),
        .class_a_i  (class_a),
        .class_b_i  (class_b),
        .tag_i      (issue_tag_i),
        .valid_i    (minmax_valid),
        .busy_o     (busy_o),
        .res_o      (minmax_bus.producer)
    );

    result_arbiter u_arb (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .mul_i   (mul_bus.consumer),
        .minmax_i(minmax_bus.consumer),
        .sel_o   (sel_bus.producer)
    );

    float_rounder u_round (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .stall_i (stall_i),
        .flush_i (flush_i),
        .in_i    (sel_bus.consumer),
        .result_o(out_result_o),
        .flags_o (out_flags_o),
        .tag_o   (out_tag_o),
        .valid_o (out_valid_o)
    );

endmodule : fpu_unit

/* testbench/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    // Free running clock with a 4 ns period
    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    // Reset is held low over the first 16 rising edges and let go on a falling edge
    initial begin
        rst_n_o = 1'b0;
        repeat (16) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule : tb_clock_gen

/* testbench/tb_fpu_unit.sv */
`timescale 1ns/10ps

module tb_fpu_unit import fpu_pkg::*; ();

    localparam int CORE_STAGES    = 2;
    localparam int NUM_ISSUES     = 400;
    localparam int FLUSH_AT       = 200;
    localparam int MUL_LATENCY    = 3 + CORE_STAGES;
    localparam int TIMEOUT_CYCLES = NUM_ISSUES * (3 + CORE_STAGES + 16);

    logic       clk;
    logic       rst_n;
    logic       stall;
    logic       flush;
    logic       issue_valid;
    fpu_op_t    issue_op;
    float_t     operand_a;
    float_t     operand_b;
    tag_t       issue_tag;
    logic       busy;
    logic       out_valid;
    float_t     out_result;
    fpu_flags_t out_flags;
    tag_t       out_tag;

    // Scoreboard indexed by tag
    logic       pending [16] = '{default: 1'b0};
    fpu_op_t    pend_op [16];
    float_t     exp_result [16];
    fpu_flags_t exp_flags [16];
    int         due_edge [16];
    // Count of unstalled rising edges that times the multiply latency
    int         active_edge = 0;
    int         cycle_count = 0;
    int         issued      = 0;
    int         outstanding = 0;

    tb_clock_gen u_clock (.clk_o(clk), .rst_n_o(rst_n));

    fpu_unit #(
        .CORE_STAGES(CORE_STAGES)
    ) uut (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .stall_i      (stall),
        .flush_i      (flush),
        .issue_valid_i(issue_valid),
        .issue_op_i   (issue_op),
        .operand_a_i  (operand_a),
        .operand_b_i  (operand_b),
        .issue_tag_i  (issue_tag),
        .busy_o       (busy),
        .out_valid_o  (out_valid),
        .out_result_o (out_result),
        .out_flags_o  (out_flags),
        .out_tag_o    (out_tag)
    );

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_result(input float_t expected, input float_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("error at %0t: out_result_o is %h, expected %h",
                                     $time, actual, expected));
        end
    endtask

    task automatic check_flags(input fpu_flags_t expected, input fpu_flags_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("error at %0t: out_flags_o is %b, expected %b",
                                     $time, actual, expected));
        end
    endtask

    task automatic check_tag(input tag_t expected, input tag_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("error at %0t: out_tag_o is %0d, expected %0d",
                                     $time, actual, expected));
        end
    endtask

    // ====================
    // Reference model
    // ====================

    function automatic logic is_nan(input float_t v);
        return (v.exponent == 8'hFF) && (v.significand != '0);
    endfunction

    function automatic logic is_inf(input float_t v);
        return (v.exponent == 8'hFF) && (v.significand == '0);
    endfunction

    function automatic void model_mul(input float_t a, input float_t b,
                                      output float_t res, output fpu_flags_t fl);
        logic   a_zero;
        logic   b_zero;
        longint prod;
        longint sig;
        longint rem;
        longint half;
        int     shift;
        int     exp;
        a_zero = (a.exponent == 8'h00) && (a.significand == '0);
        b_zero = (b.exponent == 8'h00) && (b.significand == '0);
        res = '{sign: a.sign ^ b.sign, exponent: 8'h00, significand: 23'h0};
        fl  = '0;
        if (is_nan(a) || is_nan(b) || (is_inf(a) && b_zero) || (is_inf(b) && a_zero)) begin
            res = CANONICAL_NAN;
            fl.invalid = 1'b1;
        end else if (is_inf(a) || is_inf(b)) begin
            // An infinite factor is reported the same way as a range overflow
            res.exponent = 8'hFF;
            fl.overflow  = 1'b1;
        end else if (a.exponent != 8'h00 && b.exponent != 8'h00) begin
            // Subnormal or zero factors skip this branch and leave signed zero
            prod  = longint'({1'b1, a.significand}) * longint'({1'b1, b.significand});
            shift = (prod >= (longint'(1) << 47)) ? 24 : 23;
            exp   = int'(a.exponent) + int'(b.exponent) - BIAS + shift - 23;
            sig   = prod >> shift;
            rem   = prod - (sig << shift);
            half  = longint'(1) << (shift - 1);
            if (exp < MIN_EXP) begin
                fl.underflow = 1'b1;
            end else if (exp >= 255) begin
                res.exponent = 8'hFF;
                fl.overflow  = 1'b1;
            end else begin
                // Ties go to the even significand
                if (rem > half || (rem == half && sig[0])) begin
                    sig++;
                end
                if (sig == (longint'(1) << 24)) begin
                    sig = sig >> 1;
                    exp++;
                end
                if (exp == 255) begin
                    res.exponent = 8'hFF;
                    fl.overflow  = 1'b1;
                end else begin
                    res.exponent    = 8'(exp);
                    res.significand = 23'(sig);
                end
            end
        end
    endfunction

    function automatic void model_min_max(input fpu_op_t op, input float_t a, input float_t b,
                                          output float_t res, output fpu_flags_t fl);
        longint key_a;
        longint key_b;
        // Negative values map below all positive ones and -0 lands just under +0
        key_a = a.sign ? -longint'(a[30:0]) - 1 : longint'(a[30:0]);
        key_b = b.sign ? -longint'(b[30:0]) - 1 : longint'(b[30:0]);
        fl = '0;
        if (is_nan(a) || is_nan(b)) begin
            res = CANONICAL_NAN;
            fl.invalid = 1'b1;
        end else if (op == OP_MIN) begin
            res = (key_a < key_b) ? a : b;
        end else begin
            res = (key_a < key_b) ? b : a;
        end
    endfunction

    // ====================
    // Scoreboard
    // ====================

    task automatic record_issue();
        float_t     r;
        fpu_flags_t f;
        if (issue_op == OP_MUL) begin
            model_mul(operand_a, operand_b, r, f);
        end else begin
            model_min_max(issue_op, operand_a, operand_b, r, f);
        end
        exp_result[issue_tag] = r;
        exp_flags[issue_tag]  = f;
        pend_op[issue_tag]    = issue_op;
        due_edge[issue_tag]   = active_edge + MUL_LATENCY;
        pending[issue_tag]    = 1'b1;
        outstanding++;
    endtask

    task automatic retire_result();
        tag_t t;
        t = out_tag;
        // A multiply that is due now must be the one on the output
        for (int i = 0; i < 16; i++) begin
            if (pending[i] && pend_op[i] == OP_MUL && due_edge[i] == active_edge) begin
                check_tag(tag_t'(i), t);
            end
        end
        if (!pending[t]) begin
            report_failure($sformatf("result returned for tag %0d with nothing in flight", t));
        end else if (pend_op[t] == OP_MUL && due_edge[t] != active_edge) begin
            report_failure($sformatf("multiply with tag %0d returned at the wrong cycle", t));
        end else begin
            check_result(exp_result[t], out_result);
            check_flags(exp_flags[t], out_flags);
            pending[t] = 1'b0;
            outstanding--;
        end
    endtask

    task automatic check_due_multiplies();
        for (int i = 0; i < 16; i++) begin
            if (pending[i] && pend_op[i] == OP_MUL && due_edge[i] <= active_edge) begin
                report_failure($sformatf("multiply with tag %0d missed its return cycle", i));
            end
        end
    endtask

    task automatic drop_in_flight();
        for (int i = 0; i < 16; i++) begin
            pending[i] = 1'b0;
        end
        outstanding = 0;
    endtask

    // Inputs change on the falling edge, so values read here are the settled ones
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            report_failure($sformatf("timeout after %0d cycles with %0d results outstanding",
                                     cycle_count, outstanding));
        end else if (rst_n && stall) begin
            if (out_valid) begin
                report_failure("out_valid_o was high while stall_i was high");
            end
        end else if (rst_n) begin
            active_edge++;
            if (out_valid) begin
                retire_result();
            end
            check_due_multiplies();
            if (flush) begin
                drop_in_flight();
            end else if (issue_valid && !busy) begin
                record_issue();
            end
        end
    end

    // ====================
    // Stimulus
    // ====================

    function automatic float_t random_operand();
        float_t v;
        v.sign        = 1'($urandom);
        v.significand = 23'($urandom);
        v.exponent    = 8'($urandom_range(97, 157));
        case ($urandom_range(0, 15))
            0: begin
                v.exponent       = 8'hFF;
                v.significand[0] = 1'b1;
            end
            1: begin
                v.exponent    = 8'hFF;
                v.significand = '0;
            end
            2: begin
                v.exponent    = 8'h00;
                v.significand = '0;
            end
            3: begin
                v.exponent       = 8'h00;
                v.significand[0] = 1'b1;
            end
            4: v.exponent = 8'($urandom_range(190, 254));
            5: v.exponent = 8'($urandom_range(1, 50));
            // Significands near all ones or near 1.0 can carry into the exponent
            6: v.significand = 23'h7FFFFF - 23'($urandom_range(0, 3));
            7: v.significand = 23'($urandom_range(0, 3));
            default: ;
        endcase
        return v;
    endfunction

    task automatic flush_pipeline();
        stall       = 1'b0;
        issue_valid = 1'b0;
        flush       = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        // Any result of a dropped operation shows up here without a pending tag
        repeat (24) @(negedge clk);
    endtask

    initial begin
        int next_tag = 0;
        bit flushed  = 1'b0;
        void'($urandom(32'h1547a4cd));
        stall       = 1'b0;
        flush       = 1'b0;
        issue_valid = 1'b0;
        issue_op    = OP_MUL;
        operand_a   = '0;
        operand_b   = '0;
        issue_tag   = '0;
        wait (rst_n === 1'b1);
        @(negedge clk);
        if (out_valid || busy) begin
            report_failure("out_valid_o or busy_o was high after reset");
        end
        while (issued < NUM_ISSUES) begin
            if (issued == FLUSH_AT && !flushed) begin
                flushed = 1'b1;
                flush_pipeline();
            end else begin
                stall       = ($urandom_range(0, 15) == 0);
                issue_valid = 1'b0;
                // Tags rotate, so at most 16 operations are ever in flight
                if (!stall && !busy && !pending[next_tag] && $urandom_range(0, 3) != 0) begin
                    issue_valid = 1'b1;
                    issue_op    = fpu_op_t'($urandom_range(0, 2));
                    operand_a   = random_operand();
                    operand_b   = random_operand();
                    issue_tag   = tag_t'(next_tag);
                    next_tag    = (next_tag + 1) % 16;
                    issued++;
                end
                @(negedge clk);
            end
        end
        stall       = 1'b0;
        issue_valid = 1'b0;
        while (outstanding != 0) begin
            @(negedge clk);
        end
        repeat (8) @(negedge clk);
        $display("NO ERRORS");
        $finish;
    end

endmodule : tb_fpu_unit

/* vlog.f */
logic/fpu_pkg.sv
logic/result_bus_if.sv
logic/float_classifier.sv
logic/significand_multiplier.sv
logic/float_multiplier.sv
logic/float_min_max.sv
logic/result_arbiter.sv
logic/float_rounder.sv
logic/fpu_unit.sv
testbench/tb_clock_gen.sv
testbench/tb_fpu_unit.sv
